//--- src/bpu_macros.svh
`ifndef BPU_MACROS_SVH
`define BPU_MACROS_SVH

// datapath width
`define BPU_XLEN 32

// bimodal direction table, indexed by pc[9:1]
`define BPU_BM_ENTRIES 512
`define BPU_BM_IDX_W 9

// direct-mapped btb, index pc[9:2] and tag pc[31:10]
`define BPU_BTB_ENTRIES 256
`define BPU_BTB_IDX_W 8
`define BPU_BTB_TAG_W 22

// return address stack, count is one bit wider than the index
`define BPU_RAS_DEPTH 64
`define BPU_RAS_PTR_W 7

// risc-v control transfer opcodes
`define BPU_OP_BRANCH 7'b1100011
`define BPU_OP_JAL 7'b1101111
`define BPU_OP_JALR 7'b1100111

// apb register map
`define BPU_REG_CTRL 8'h00
`define BPU_REG_TOTAL 8'h04
`define BPU_REG_CORRECT 8'h08

`endif

//--- src/bpu_pkg.sv
`include "bpu_macros.svh"

package bpu_pkg;

    // pc and target addresses
    typedef logic [`BPU_XLEN-1:0] addr_t;
    // raw 32-bit instruction word
    typedef logic [`BPU_XLEN-1:0] inst_t;

    typedef logic [1:0] ctr2_t; // saturating direction counter

    // table index and tag vectors
    typedef logic [`BPU_BM_IDX_W-1:0] bm_idx_t;
    typedef logic [`BPU_BTB_IDX_W-1:0] btb_idx_t;
    typedef logic [`BPU_BTB_TAG_W-1:0] btb_tag_t;

    typedef logic [`BPU_RAS_PTR_W-1:0] ras_cnt_t; // stack occupancy, 0..64

    typedef logic [7:0] apb_addr_t; // byte offset into register block

endpackage

//--- src/bimodal_predictor.sv
`timescale 1ns/1ns
`include "bpu_macros.svh"

module bimodal_predictor (
    input  logic           clk,
    input  logic           rst,
    input  bpu_pkg::addr_t lookup_pc_i,
    output logic           taken_o,
    input  logic           train_valid_i,
    input  bpu_pkg::addr_t train_pc_i,
    input  logic           train_taken_i
);

    bpu_pkg::ctr2_t ctr_q [`BPU_BM_ENTRIES];

    bpu_pkg::bm_idx_t lookup_idx;
    bpu_pkg::bm_idx_t train_idx;
    bpu_pkg::ctr2_t   train_ctr;
    bpu_pkg::ctr2_t   train_ctr_nxt;

    // bit 0 of the pc is always zero, skip it
    assign lookup_idx = lookup_pc_i[`BPU_BM_IDX_W:1];
    assign train_idx  = train_pc_i[`BPU_BM_IDX_W:1];

    assign taken_o   = ctr_q[lookup_idx][1]; // msb is the direction
    assign train_ctr = ctr_q[train_idx];

    // saturate at 00 and 11
    always_comb begin
        train_ctr_nxt = train_ctr;
        if (train_taken_i && (train_ctr != 2'b11)) begin
            train_ctr_nxt = train_ctr + 2'b01;
        end else if (!train_taken_i && (train_ctr != 2'b00)) begin
            train_ctr_nxt = train_ctr - 2'b01;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `BPU_BM_ENTRIES; i++) begin
                ctr_q[i] <= 2'b01; // weakly not taken
            end
        end else if (train_valid_i) begin
            ctr_q[train_idx] <= train_ctr_nxt;
        end
    end

    // a resolved branch must carry a real pc
    a_train_pc_known: assert property (
        @(posedge clk) disable iff (rst) train_valid_i |-> !$isunknown(train_pc_i)
    );

endmodule

//--- src/branch_target_buffer.sv
`timescale 1ns/1ns
`include "bpu_macros.svh"

module branch_target_buffer (
    input  logic           clk,
    input  logic           rst,
    input  bpu_pkg::addr_t lookup_pc_i,
    output logic           hit_o,
    output bpu_pkg::addr_t target_o,
    input  logic           fill_i,
    input  bpu_pkg::addr_t fill_pc_i,
    input  bpu_pkg::addr_t fill_target_i
);

    logic [`BPU_BTB_ENTRIES-1:0] valid_q;
    bpu_pkg::btb_tag_t           tag_q [`BPU_BTB_ENTRIES];
    bpu_pkg::addr_t              target_q [`BPU_BTB_ENTRIES];

    bpu_pkg::btb_idx_t lookup_idx;
    bpu_pkg::btb_tag_t lookup_tag;
    bpu_pkg::btb_idx_t fill_idx;
    bpu_pkg::btb_tag_t fill_tag;

    // word aligned index and upper bits as tag
    assign lookup_idx = lookup_pc_i[`BPU_BTB_IDX_W+1:2];
    assign lookup_tag = lookup_pc_i[`BPU_XLEN-1:`BPU_XLEN-`BPU_BTB_TAG_W];
    assign fill_idx   = fill_pc_i[`BPU_BTB_IDX_W+1:2];
    assign fill_tag   = fill_pc_i[`BPU_XLEN-1:`BPU_XLEN-`BPU_BTB_TAG_W];

    assign hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    assign target_o = target_q[lookup_idx];

    // valid bit per entry
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[fill_idx] <= 1'b1;
        end
    end

    // tag and target written on every fill
    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_q[fill_idx]    <= fill_tag;
            target_q[fill_idx] <= fill_target_i;
        end
    end

endmodule

//--- src/return_address_stack.sv
`timescale 1ns/1ns
`include "bpu_macros.svh"

module return_address_stack (
    input  logic           clk,
    input  logic           rst,
    input  logic           push_i,
    input  bpu_pkg::addr_t push_addr_i,
    input  logic           pop_i,
    output bpu_pkg::addr_t top_o,
    output logic           empty_o
);

    bpu_pkg::addr_t stack_q [`BPU_RAS_DEPTH];

    bpu_pkg::ras_cnt_t cnt_q;
    bpu_pkg::ras_cnt_t cnt_pop;  // count after the pop
    bpu_pkg::ras_cnt_t cnt_nxt;
    bpu_pkg::ras_cnt_t top_cnt;
    logic              do_pop;
    logic              do_push;
    logic [`BPU_RAS_PTR_W-2:0] wr_idx;
    logic [`BPU_RAS_PTR_W-2:0] top_idx;

    // pop first, then push into the freed slot
    assign do_pop  = pop_i && (cnt_q != '0);
    assign cnt_pop = do_pop ? cnt_q - `BPU_RAS_PTR_W'(1) : cnt_q;
    assign do_push = push_i && (cnt_pop != `BPU_RAS_PTR_W'(`BPU_RAS_DEPTH));
    assign cnt_nxt = do_push ? cnt_pop + `BPU_RAS_PTR_W'(1) : cnt_pop;

    assign wr_idx  = cnt_pop[`BPU_RAS_PTR_W-2:0];
    assign top_cnt = cnt_q - `BPU_RAS_PTR_W'(1);
    assign top_idx = top_cnt[`BPU_RAS_PTR_W-2:0];

    assign empty_o = (cnt_q == '0);
    assign top_o   = empty_o ? '0 : stack_q[top_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_nxt;
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_q[wr_idx] <= push_addr_i;
        end
    end

    // occupancy never passes the depth
    a_cnt_in_range: assert property (
        @(posedge clk) disable iff (rst) cnt_q <= `BPU_RAS_PTR_W'(`BPU_RAS_DEPTH)
    );

endmodule

//--- src/bpu_csr.sv
`timescale 1ns/1ns
`include "bpu_macros.svh"

module bpu_csr (
    input  logic               clk,
    input  logic               rst,
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  bpu_pkg::apb_addr_t paddr_i,
    input  bpu_pkg::addr_t     pwdata_i,
    output bpu_pkg::addr_t     prdata_o,
    input  logic               resolve_i,
    input  logic               resolve_correct_i,
    output logic               predict_en_o
);

    logic                 predict_en_q;
    logic [`BPU_XLEN-1:0] total_q;   // resolved branches
    logic [`BPU_XLEN-1:0] correct_q; // correctly predicted ones
    logic                 wr_en;
    logic                 rd_en;

    // zero-wait apb, everything happens in the access phase
    assign wr_en = psel_i && penable_i && pwrite_i;
    assign rd_en = psel_i && !pwrite_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            predict_en_q <= 1'b1; // prediction on out of reset
            total_q      <= '0;
            correct_q    <= '0;
        end else begin
            if (wr_en && (paddr_i == `BPU_REG_CTRL)) begin
                predict_en_q <= pwdata_i[0];
            end
            if (resolve_i) begin
                total_q <= total_q + `BPU_XLEN'(1);
                if (resolve_correct_i) begin
                    correct_q <= correct_q + `BPU_XLEN'(1);
                end
            end
        end
    end

    // read mux, unmapped offsets read zero
    always_comb begin
        prdata_o = '0;
        if (rd_en) begin
            case (paddr_i)
                `BPU_REG_CTRL:    prdata_o = {{(`BPU_XLEN-1){1'b0}}, predict_en_q};
                `BPU_REG_TOTAL:   prdata_o = total_q;
                `BPU_REG_CORRECT: prdata_o = correct_q;
                default:          prdata_o = '0;
            endcase
        end
    end

    assign predict_en_o = predict_en_q;

    a_penable_in_psel: assert property (
        @(posedge clk) disable iff (rst) penable_i |-> psel_i
    );

endmodule

//--- src/bpu_top.sv
`timescale 1ns/1ns
`include "bpu_macros.svh"

module bpu_top (
    input  logic               clk,
    input  logic               rst,
    input  bpu_pkg::addr_t     if_pc_i,
    input  bpu_pkg::inst_t     if_inst_i,
    input  logic               ex_branch_valid_i,
    input  logic               ex_branch_taken_i,
    input  logic               ex_pdt_true_i,
    input  bpu_pkg::addr_t     ex_pc_i,
    input  bpu_pkg::addr_t     ex_target_i,
    input  bpu_pkg::inst_t     ex_inst_i,
    input  logic               ex_stall_i,
    input  logic               id_ras_push_valid_i,
    input  bpu_pkg::addr_t     id_ras_push_data_i,
    input  logic               id_stall_i,
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  bpu_pkg::apb_addr_t paddr_i,
    input  bpu_pkg::addr_t     pwdata_i,
    output bpu_pkg::addr_t     prdata_o,
    output logic               branch_or_not_o,
    output logic               pdt_taken_o,
    output bpu_pkg::addr_t     pdt_pc_o
);

    logic           is_branch, is_jal, is_jalr, is_ret;
    logic           ex_is_branch, ex_is_ret;
    logic           bm_taken, btb_hit, ras_empty, predict_en;
    logic           ras_push, ras_pop, pred_taken;
    bpu_pkg::addr_t btb_target, ras_top, pc_plus4, pred_pc, b_off, j_off;

    // jalr x0, 0(x1) or jalr x0, 0(x5)
    function automatic logic is_return(input bpu_pkg::inst_t inst);
        logic rs1_link;
        rs1_link = (inst[19:15] == 5'd1) || (inst[19:15] == 5'd5);
        return (inst[6:0] == `BPU_OP_JALR) && (inst[11:7] == 5'd0) && rs1_link
            && (inst[31:20] == 12'd0);
    endfunction

    assign is_branch    = (if_inst_i[6:0] == `BPU_OP_BRANCH);
    assign is_jal       = (if_inst_i[6:0] == `BPU_OP_JAL);
    assign is_jalr      = (if_inst_i[6:0] == `BPU_OP_JALR);
    assign is_ret       = is_return(if_inst_i);
    assign ex_is_branch = (ex_inst_i[6:0] == `BPU_OP_BRANCH);
    assign ex_is_ret    = is_return(ex_inst_i);

    // sign-extended b and j immediates
    assign b_off = {{20{if_inst_i[31]}}, if_inst_i[7], if_inst_i[30:25], if_inst_i[11:8], 1'b0};
    assign j_off = {{12{if_inst_i[31]}}, if_inst_i[19:12], if_inst_i[20], if_inst_i[30:21],
                    1'b0};
    assign pc_plus4 = if_pc_i + `BPU_XLEN'(4);

    // stack updates are held off by stalls
    assign ras_push = id_ras_push_valid_i && !id_stall_i && !ex_stall_i;
    assign ras_pop  = ex_branch_valid_i && ex_branch_taken_i && ex_is_ret && !ex_stall_i;

    // priority: return, jal, taken conditional branch, fall through
    always_comb begin
        pred_taken = 1'b0;
        pred_pc    = pc_plus4;
        if (is_ret) begin
            if (!ras_empty) begin
                pred_taken = 1'b1;
                pred_pc    = ras_top;
            end
        end else if (is_jal) begin
            pred_taken = 1'b1;
            pred_pc    = btb_hit ? btb_target : if_pc_i + j_off;
        end else if (is_branch && bm_taken) begin
            pred_taken = 1'b1;
            pred_pc    = btb_hit ? btb_target : if_pc_i + b_off;
        end
    end

    assign branch_or_not_o = is_branch || is_jal || is_jalr; // decode only, not gated
    assign pdt_taken_o     = predict_en && pred_taken;
    assign pdt_pc_o        = pdt_taken_o ? pred_pc : pc_plus4;

    bimodal_predictor u_bimodal (
        .clk(clk), .rst(rst), .lookup_pc_i(if_pc_i), .taken_o(bm_taken),
        .train_valid_i(ex_branch_valid_i && ex_is_branch), .train_pc_i(ex_pc_i),
        .train_taken_i(ex_branch_taken_i)
    );

    branch_target_buffer u_btb (
        .clk(clk), .rst(rst), .lookup_pc_i(if_pc_i), .hit_o(btb_hit), .target_o(btb_target),
        .fill_i(ex_branch_valid_i && ex_branch_taken_i), .fill_pc_i(ex_pc_i),
        .fill_target_i(ex_target_i)
    );

    return_address_stack u_ras (
        .clk(clk), .rst(rst), .push_i(ras_push), .push_addr_i(id_ras_push_data_i),
        .pop_i(ras_pop), .top_o(ras_top), .empty_o(ras_empty)
    );

    bpu_csr u_csr (
        .clk(clk), .rst(rst), .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
        .resolve_i(ex_branch_valid_i), .resolve_correct_i(ex_pdt_true_i),
        .predict_en_o(predict_en)
    );

endmodule

//--- testbench/tb_bpu.sv
`timescale 1ns/1ns
`include "bpu_macros.svh"

module tb_bpu;

    localparam int SETTLE_LIMIT = 4;     // cycles allowed for a prediction to settle
    localparam logic [31:0] INST_ADDI = 32'h00500093;
    localparam logic [31:0] INST_RET  = {12'h000, 5'd1, 3'b000, 5'd0, `BPU_OP_JALR};

    logic clk, rst;
    bpu_pkg::addr_t if_pc, ex_pc, ex_target, id_ras_push_data, pwdata, exp_pc, exp_rdata;
    bpu_pkg::inst_t if_inst, ex_inst;
    bpu_pkg::apb_addr_t paddr;
    logic ex_branch_valid, ex_branch_taken, ex_pdt_true, ex_stall;
    logic id_ras_push_valid, id_stall, psel, penable, pwrite;
    logic exp_branch, exp_taken, chk_en, rd_chk;
    wire  bpu_pkg::addr_t prdata, pdt_pc;
    wire  branch_or_not, pdt_taken;

    logic [15:0] lfsr_q;
    int pred_errors, apb_errors, timeouts, res_total, res_correct;

    bpu_top UUT (
        .clk(clk), .rst(rst), .if_pc_i(if_pc), .if_inst_i(if_inst),
        .ex_branch_valid_i(ex_branch_valid), .ex_branch_taken_i(ex_branch_taken),
        .ex_pdt_true_i(ex_pdt_true), .ex_pc_i(ex_pc), .ex_target_i(ex_target),
        .ex_inst_i(ex_inst), .ex_stall_i(ex_stall), .id_ras_push_valid_i(id_ras_push_valid),
        .id_ras_push_data_i(id_ras_push_data), .id_stall_i(id_stall), .psel_i(psel),
        .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr), .pwdata_i(pwdata),
        .prdata_o(prdata), .branch_or_not_o(branch_or_not), .pdt_taken_o(pdt_taken),
        .pdt_pc_o(pdt_pc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // prediction outputs against the expected values of the current fetch
    a_branch_flag: assert property (@(posedge clk) disable iff (rst)
        chk_en |-> (branch_or_not == exp_branch))
        else begin
            pred_errors++;
            $display("[FAIL] %0t branch_or_not_o is %0b, expected %0b", $time,
                     $sampled(branch_or_not), $sampled(exp_branch));
        end

    a_taken_flag: assert property (@(posedge clk) disable iff (rst)
        chk_en |-> (pdt_taken == exp_taken))
        else begin
            pred_errors++;
            $display("[FAIL] %0t pdt_taken_o is %0b, expected %0b for pc %h", $time,
                     $sampled(pdt_taken), $sampled(exp_taken), $sampled(if_pc));
        end

    a_next_pc: assert property (@(posedge clk) disable iff (rst)
        chk_en |-> (pdt_pc == exp_pc))
        else begin
            pred_errors++;
            $display("[FAIL] %0t pdt_pc_o is %h, expected %h", $time,
                     $sampled(pdt_pc), $sampled(exp_pc));
        end

    a_read_data: assert property (@(posedge clk) disable iff (rst)
        rd_chk |-> (prdata == exp_rdata))
        else begin
            apb_errors++;
            $display("[FAIL] %0t apb read of %h gave %h, expected %h", $time,
                     $sampled(paddr), $sampled(prdata), $sampled(exp_rdata));
        end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return v;
    endfunction

    // random upper bits around a fixed table index so tests do not alias
    function automatic bpu_pkg::addr_t rand_pc(input logic [7:0] idx);
        logic [31:0] r;
        r = rand_bits(22);
        return {r[21:0], idx, 2'b00};
    endfunction

    function automatic bpu_pkg::inst_t enc_branch(input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], `BPU_OP_BRANCH};
    endfunction

    function automatic bpu_pkg::inst_t enc_jal(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, `BPU_OP_JAL};
    endfunction

    // present one fetch and let the assertions check it
    task automatic fetch(input bpu_pkg::addr_t pc, input bpu_pkg::inst_t inst,
                         input logic br, input logic tk, input bpu_pkg::addr_t tgt);
        bpu_pkg::addr_t want_pc;
        int n;
        want_pc = tk ? tgt : pc + 32'd4;
        n = 0;
        @(posedge clk);
        if_pc      <= pc;
        if_inst    <= inst;
        exp_branch <= br;
        exp_taken  <= tk;
        exp_pc     <= want_pc;
        chk_en     <= 1'b1;
        @(negedge clk);
        while (pdt_pc !== want_pc && n < SETTLE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (pdt_pc !== want_pc) begin
            timeouts++;
            $display("prediction for pc %h did not settle within %0d cycles", pc, n);
        end
        @(posedge clk);
        chk_en <= 1'b0;
    endtask

    task automatic resolve(input bpu_pkg::addr_t pc, input bpu_pkg::inst_t inst,
                           input logic taken, input bpu_pkg::addr_t tgt, input logic correct);
        @(posedge clk);
        ex_branch_valid <= 1'b1;
        ex_branch_taken <= taken;
        ex_pdt_true     <= correct;
        ex_pc           <= pc;
        ex_inst         <= inst;
        ex_target       <= tgt;
        @(posedge clk);
        ex_branch_valid <= 1'b0;
        res_total++;
        if (correct) res_correct++;
    endtask

    task automatic push_ras(input bpu_pkg::addr_t addr);
        @(posedge clk);
        id_ras_push_valid <= 1'b1;
        id_ras_push_data  <= addr;
        @(posedge clk);
        id_ras_push_valid <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel   <= 1'b1;
        pwrite <= 1'b1;
        paddr  <= addr;
        pwdata <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read_check(input logic [7:0] addr, input logic [31:0] want);
        @(posedge clk);
        psel   <= 1'b1;
        pwrite <= 1'b0;
        paddr  <= addr;
        @(posedge clk);
        penable   <= 1'b1;
        rd_chk    <= 1'b1;
        exp_rdata <= want;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        rd_chk  <= 1'b0;
    endtask

    initial begin
        #100000;
        $display("simulation timed out before the stimulus finished");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        bpu_pkg::addr_t br_pc, br_tgt, jal_pc, jal_tgt, ret_pc, ra_a, ra_b;
        bpu_pkg::inst_t br_inst, jal_inst;
        logic [31:0] r;
        logic [20:0] j_off;
        lfsr_q = 16'd42443;
        rst = 1'b1;
        if_pc = '0;
        if_inst = '0;
        {ex_branch_valid, ex_branch_taken, ex_pdt_true, ex_stall} = '0;
        {ex_pc, ex_target, ex_inst} = '0;
        {id_ras_push_valid, id_ras_push_data, id_stall} = '0;
        {psel, penable, pwrite, paddr, pwdata} = '0;
        {exp_branch, exp_taken, exp_pc, exp_rdata, chk_en, rd_chk} = '0;
        {pred_errors, apb_errors, timeouts, res_total, res_correct} = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // decode after reset
        fetch(rand_pc(8'h05), INST_ADDI, 1'b0, 1'b0, '0);
        br_pc = rand_pc(8'h10);
        r = rand_bits(12);
        br_inst = enc_branch({r[11:0], 1'b0});
        fetch(br_pc, br_inst, 1'b1, 1'b0, '0);
        ret_pc = rand_pc(8'h40);
        fetch(ret_pc, INST_RET, 1'b1, 1'b0, '0);   // empty stack

        // bimodal training with the target from the btb
        br_tgt = rand_pc(8'h77);
        resolve(br_pc, br_inst, 1'b1, br_tgt, 1'b0);
        fetch(br_pc, br_inst, 1'b1, 1'b1, br_tgt);
        resolve(br_pc, br_inst, 1'b0, br_pc + 32'd4, 1'b0);
        resolve(br_pc, br_inst, 1'b0, br_pc + 32'd4, 1'b1);
        fetch(br_pc, br_inst, 1'b1, 1'b0, '0);

        // jal without a btb entry
        jal_pc = rand_pc(8'h20);
        r = rand_bits(20);
        j_off = {r[19:0], 1'b0};
        jal_inst = enc_jal(j_off);
        jal_tgt = jal_pc + {{11{j_off[20]}}, j_off};
        fetch(jal_pc, jal_inst, 1'b1, 1'b1, jal_tgt);

        // return stack
        ra_a = rand_pc(8'h51);
        ra_b = rand_pc(8'h62);
        push_ras(ra_a);
        push_ras(ra_b);
        fetch(ret_pc, INST_RET, 1'b1, 1'b1, ra_b);
        resolve(ret_pc, INST_RET, 1'b1, ra_b, 1'b1);
        fetch(ret_pc, INST_RET, 1'b1, 1'b1, ra_a);
        resolve(ret_pc, INST_RET, 1'b1, ra_a, 1'b1);
        fetch(ret_pc, INST_RET, 1'b1, 1'b0, '0);

        // statistics and then prediction enable
        for (int i = 0; i < 5; i++) begin
            r = rand_bits(1);
            resolve(br_pc, br_inst, 1'b1, br_tgt, r[0]); // branch ends strongly taken
        end
        apb_read_check(`BPU_REG_TOTAL, res_total);
        apb_read_check(`BPU_REG_CORRECT, res_correct);
        apb_write(`BPU_REG_CTRL, 32'd0);
        apb_read_check(`BPU_REG_CTRL, 32'd0);
        fetch(jal_pc, jal_inst, 1'b1, 1'b0, '0);
        fetch(br_pc, br_inst, 1'b1, 1'b0, '0);
        apb_write(`BPU_REG_CTRL, 32'd1);
        fetch(jal_pc, jal_inst, 1'b1, 1'b1, jal_tgt);
        fetch(br_pc, br_inst, 1'b1, 1'b1, br_tgt);

        repeat (2) @(posedge clk);
        $display("errors: prediction %0d, apb %0d, timeouts %0d",
                 pred_errors, apb_errors, timeouts);
        if (pred_errors == 0 && apb_errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- bpu.f
+incdir+src
src/bpu_pkg.sv
src/bimodal_predictor.sv
src/branch_target_buffer.sv
src/return_address_stack.sv
src/bpu_csr.sv
src/bpu_top.sv
testbench/tb_bpu.sv

//--- run_sim.sh
#!/bin/sh
# build and run the bpu testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_bpu -f bpu.f -o sim_bpu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_bpu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST PASSED" "$LOG"; then
    exit 0
fi
exit 1
